/* hdl/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// width of the integer data path
`define EX_XLEN 32

// one restoring step per quotient bit
`define EX_DIV_CYCLES 32

// start to done for the multiplier,
// operand register plus product register
`define EX_MUL_LATENCY 2

`endif

/* hdl/ex_pkg.sv */
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]   bus32_t;
    typedef logic [2*`EX_XLEN-1:0] bus64_t;
    typedef logic [3:0]            strb_t;
    typedef logic [4:0]            reg_idx_t;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_LU12I,
        OP_MULW, OP_MULHW, OP_MULHWU,
        OP_DIVW, OP_MODW, OP_DIVWU, OP_MODWU,
        OP_LDB, OP_LDH, OP_LDW,
        OP_STB, OP_STH, OP_STW
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_ARITH = 3'd0,
        SEL_MUL   = 3'd1,
        SEL_DIV   = 3'd2,
        SEL_MEM   = 3'd3
    } alu_sel_e;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        alu_sel_e sel;
        bus32_t   src1;
        bus32_t   src2;
        bus32_t   imm;
        reg_idx_t rd;
        logic     we;
    } dispatch_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     we;
        bus32_t   wb_data;
        bus32_t   mem_addr;
        logic     is_store;
        logic     ale;
    } ex_mem_t;

    // result class, decoded once at dispatch
    function automatic alu_sel_e class_of(alu_op_e op);
        case (op)
            OP_MULW, OP_MULHW, OP_MULHWU:           return SEL_MUL;
            OP_DIVW, OP_MODW, OP_DIVWU, OP_MODWU:   return SEL_DIV;
            OP_LDB, OP_LDH, OP_LDW,
            OP_STB, OP_STH, OP_STW:                 return SEL_MEM;
            default:                                return SEL_ARITH;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/ex_pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    // hold wins over bubble, a stalled slot keeps its item
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q <= '0;
        end else if (!hold_i) begin
            if (bubble_i) begin
                q <= '0;
            end else begin
                q <= d_i;
            end
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

/* hdl/ex_int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_int_alu (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::bus32_t  a_i,
    input  ex_pkg::bus32_t  b_i,
    output ex_pkg::bus32_t  res_o
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            OP_ADD: begin
                res_o = a_i + b_i;
            end
            OP_SUB: begin
                res_o = a_i - b_i;
            end
            OP_SLT: begin
                res_o = bus32_t'($signed(a_i) < $signed(b_i));
            end
            OP_SLTU: begin
                res_o = bus32_t'(a_i < b_i);
            end
            OP_AND: begin
                res_o = a_i & b_i;
            end
            OP_OR: begin
                res_o = a_i | b_i;
            end
            OP_XOR: begin
                res_o = a_i ^ b_i;
            end
            OP_NOR: begin
                res_o = ~(a_i | b_i);
            end
            OP_SLL: begin
                res_o = a_i << shamt;
            end
            OP_SRL: begin
                res_o = a_i >> shamt;
            end
            OP_SRA: begin
                res_o = bus32_t'($signed(a_i) >>> shamt);
            end
            // upper immediate arrives already placed in b
            OP_LU12I: begin
                res_o = b_i;
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ex_mul_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_mul_unit (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  ex_pkg::bus32_t a_i,
    input  ex_pkg::bus32_t b_i,
    output logic           done_o,
    output ex_pkg::bus64_t product_o
);
    import ex_pkg::*;

    localparam int LAT = `EX_MUL_LATENCY;

    logic [LAT-1:0]                 stage_q;
    logic signed [`EX_XLEN:0]       a_q;
    logic signed [`EX_XLEN:0]       b_q;
    logic signed [2*`EX_XLEN+1:0]   full_prod;
    bus64_t                         product_q;

    // one extra bit so unsigned operands multiply as positive signed
    assign full_prod = a_q * b_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[LAT-2:0], start_i};
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q <= {signed_i & a_i[`EX_XLEN-1], a_i};
            b_q <= {signed_i & b_i[`EX_XLEN-1], b_i};
        end
        if (stage_q[LAT-2]) begin
            product_q <= full_prod[2*`EX_XLEN-1:0];
        end
    end

    assign done_o    = stage_q[LAT-1];
    assign product_o = product_q;

endmodule

`default_nettype wire

/* hdl/ex_div_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_div_unit (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  ex_pkg::bus32_t dividend_i,
    input  ex_pkg::bus32_t divisor_i,
    output logic           busy_o,
    output logic           done_o,
    output ex_pkg::bus32_t quotient_o,
    output ex_pkg::bus32_t remainder_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_DIV_CYCLES + 1);
    localparam int MSB   = `EX_XLEN - 1;

    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    logic             done_q;
    bus32_t           quo_q;
    bus32_t           rem_q;
    bus32_t           dvs_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    bus32_t           dividend_mag;
    bus32_t           divisor_mag;
    logic [`EX_XLEN:0] shifted;
    logic [`EX_XLEN:0] diff;
    logic             fits;

    assign dividend_mag = (signed_i && dividend_i[MSB]) ? -dividend_i : dividend_i;
    assign divisor_mag  = (signed_i && divisor_i[MSB]) ? -divisor_i : divisor_i;

    // one restoring step, next dividend bit enters from the quotient register
    assign shifted = {rem_q, quo_q[MSB]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign fits    = shifted >= {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                cnt_q  <= CNT_W'(`EX_DIV_CYCLES);
                busy_q <= 1'b1;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q <= dividend_mag;
            rem_q <= '0;
            dvs_q <= divisor_mag;
            // zero divisor keeps the all-ones quotient unsigned
            neg_quo_q <= signed_i && (dividend_i[MSB] ^ divisor_i[MSB]) && (divisor_i != '0);
            neg_rem_q <= signed_i && dividend_i[MSB];
        end else if (busy_q) begin
            quo_q <= {quo_q[MSB-1:0], fits};
            rem_q <= fits ? diff[MSB:0] : shifted[MSB:0];
        end
    end

    assign busy_o      = busy_q;
    assign done_o      = done_q;
    assign quotient_o  = neg_quo_q ? -quo_q : quo_q;
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;

endmodule

`default_nettype wire

/* hdl/ex_lsu_agen.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_lsu_agen (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::bus32_t  base_i,
    input  ex_pkg::bus32_t  offset_i,
    input  ex_pkg::bus32_t  store_data_i,
    output ex_pkg::bus32_t  addr_o,
    output logic            req_o,
    output logic            we_o,
    output ex_pkg::strb_t   wstrb_o,
    output ex_pkg::bus32_t  wdata_o,
    output logic            ale_o
);
    import ex_pkg::*;

    logic       is_mem;
    logic [1:0] lo;

    assign addr_o = base_i + offset_i;
    assign lo     = addr_o[1:0];

    assign is_mem = op_i inside {OP_LDB, OP_LDH, OP_LDW, OP_STB, OP_STH, OP_STW};
    assign we_o   = op_i inside {OP_STB, OP_STH, OP_STW};

    always_comb begin
        case (op_i)
            OP_LDH, OP_STH: begin
                ale_o = lo[0];
            end
            OP_LDW, OP_STW: begin
                ale_o = lo != 2'b00;
            end
            default: begin
                ale_o = 1'b0;
            end
        endcase
    end

    // misaligned access never reaches the cache
    assign req_o = is_mem && !ale_o;

    always_comb begin
        wstrb_o = 4'b0000;
        wdata_o = '0;
        case (op_i)
            OP_LDB, OP_LDH, OP_LDW: begin
                wstrb_o = 4'b1111;
            end
            OP_STB: begin
                wstrb_o = 4'b0001 << lo;
                wdata_o = bus32_t'(store_data_i[7:0]) << {lo, 3'b000};
            end
            OP_STH: begin
                if (!ale_o) begin
                    wstrb_o = 4'b0011 << {lo[1], 1'b0};
                    wdata_o = bus32_t'(store_data_i[15:0]) << {lo[1], 4'b0000};
                end
            end
            OP_STW: begin
                if (!ale_o) begin
                    wstrb_o = 4'b1111;
                    wdata_o = store_data_i;
                end
            end
            default: begin
                wstrb_o = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ex_pkg::dispatch_ex_t ex_i,
    input  logic                 mem_addr_ok_i,
    output ex_pkg::ex_mem_t      ex_o,
    output logic                 pause_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output ex_pkg::bus32_t       mem_addr_o,
    output ex_pkg::bus32_t       mem_wdata_o,
    output ex_pkg::strb_t        mem_wstrb_o
);
    import ex_pkg::*;

    bus32_t     alu_res;
    logic       mul_signed;
    logic       mul_done;
    bus64_t     mul_product;
    bus32_t     mul_word;
    logic       div_signed;
    logic       div_busy;
    logic       div_done;
    bus32_t     div_quo;
    bus32_t     div_rem;
    bus32_t     div_word;
    logic [1:0] unit_pend;
    logic [1:0] unit_done;
    logic [1:0] unit_launched;
    logic [1:0] unit_start;
    logic       is_store_op;
    bus32_t     agen_offset;
    bus32_t     agen_addr;
    logic       agen_req;
    logic       agen_we;
    strb_t      agen_wstrb;
    bus32_t     agen_wdata;
    logic       agen_ale;
    logic       pause_mem;

    ex_int_alu u_int_alu (
        .op_i  (ex_i.op),
        .a_i   (ex_i.src1),
        .b_i   (ex_i.src2),
        .res_o (alu_res)
    );

    // bit 0 multiplier, bit 1 divider
    assign unit_pend[0] = ex_i.valid && (ex_i.sel == SEL_MUL) && !mul_done;
    assign unit_pend[1] = ex_i.valid && (ex_i.sel == SEL_DIV) && !div_done;
    assign unit_done    = {div_done, mul_done};

    // single start pulse per held op, rearmed by done
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            unit_start    <= '0;
            unit_launched <= '0;
        end else begin
            unit_start    <= unit_pend & ~unit_launched;
            unit_launched <= (unit_launched & ~unit_done) | unit_pend;
        end
    end

    assign mul_signed = ex_i.op inside {OP_MULW, OP_MULHW};
    assign div_signed = ex_i.op inside {OP_DIVW, OP_MODW};

    ex_mul_unit u_mul_unit (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (unit_start[0]),
        .signed_i  (mul_signed),
        .a_i       (ex_i.src1),
        .b_i       (ex_i.src2),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    ex_div_unit u_div_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (unit_start[1]),
        .signed_i    (div_signed),
        .dividend_i  (ex_i.src1),
        .divisor_i   (ex_i.src2),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (div_quo),
        .remainder_o (div_rem)
    );

    assign mul_word = (ex_i.op == OP_MULW) ? mul_product[`EX_XLEN-1:0]
                                           : mul_product[2*`EX_XLEN-1:`EX_XLEN];
    assign div_word = (ex_i.op inside {OP_DIVW, OP_DIVWU}) ? div_quo : div_rem;

    // stores take base plus imm, src2 is the data
    assign is_store_op = ex_i.op inside {OP_STB, OP_STH, OP_STW};
    assign agen_offset = is_store_op ? ex_i.imm : ex_i.src2;

    ex_lsu_agen u_lsu_agen (
        .op_i         (ex_i.op),
        .base_i       (ex_i.src1),
        .offset_i     (agen_offset),
        .store_data_i (ex_i.src2),
        .addr_o       (agen_addr),
        .req_o        (agen_req),
        .we_o         (agen_we),
        .wstrb_o      (agen_wstrb),
        .wdata_o      (agen_wdata),
        .ale_o        (agen_ale)
    );

    assign mem_req_o   = ex_i.valid && (ex_i.sel == SEL_MEM) && agen_req;
    assign mem_we_o    = agen_we;
    assign mem_addr_o  = agen_addr;
    assign mem_wdata_o = agen_wdata;
    assign mem_wstrb_o = agen_wstrb;

    assign pause_mem = mem_req_o && !mem_addr_ok_i;
    assign pause_o   = (|unit_pend) || div_busy || pause_mem;

    always_comb begin
        ex_o.valid    = ex_i.valid;
        ex_o.rd       = ex_i.rd;
        ex_o.ale      = ex_i.valid && agen_ale;
        ex_o.we       = ex_i.we && !agen_ale;
        ex_o.mem_addr = agen_addr;
        ex_o.is_store = agen_we;
        case (ex_i.sel)
            SEL_MUL: begin
                ex_o.wb_data = mul_word;
            end
            SEL_DIV: begin
                ex_o.wb_data = div_word;
            end
            // load data is returned by a later stage
            SEL_MEM: begin
                ex_o.wb_data = '0;
            end
            default: begin
                ex_o.wb_data = alu_res;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ex_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             in_valid_i,
    input  ex_pkg::alu_op_e  in_op_i,
    input  ex_pkg::bus32_t   in_src1_i,
    input  ex_pkg::bus32_t   in_src2_i,
    input  ex_pkg::bus32_t   in_imm_i,
    input  ex_pkg::reg_idx_t in_rd_i,
    input  logic             mem_addr_ok_i,
    output logic             pause_o,
    output logic             mem_req_o,
    output logic             mem_we_o,
    output ex_pkg::bus32_t   mem_addr_o,
    output ex_pkg::bus32_t   mem_wdata_o,
    output ex_pkg::strb_t    mem_wstrb_o,
    output logic             wb_valid_o,
    output ex_pkg::reg_idx_t wb_rd_o,
    output ex_pkg::bus32_t   wb_data_o,
    output logic             wb_ale_o
);
    import ex_pkg::*;

    dispatch_ex_t disp_d;
    dispatch_ex_t disp_q;
    ex_mem_t      exm_d;
    ex_mem_t      exm_q;
    logic         pause;

    always_comb begin
        disp_d.valid = in_valid_i;
        disp_d.op    = in_op_i;
        disp_d.sel   = class_of(in_op_i);
        disp_d.src1  = in_src1_i;
        disp_d.src2  = in_src2_i;
        disp_d.imm   = in_imm_i;
        disp_d.rd    = in_rd_i;
        disp_d.we    = !(in_op_i inside {OP_NOP, OP_STB, OP_STH, OP_STW});
    end

    ex_pipe_reg #(.payload_t(dispatch_ex_t)) u_disp_slot (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (pause),
        .bubble_i (!in_valid_i),
        .d_i      (disp_d),
        .q_o      (disp_q)
    );

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ex_i          (disp_q),
        .mem_addr_ok_i (mem_addr_ok_i),
        .ex_o          (exm_d),
        .pause_o       (pause),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wstrb_o   (mem_wstrb_o)
    );

    // bubble while execute is stalled
    ex_pipe_reg #(.payload_t(ex_mem_t)) u_exm_slot (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (1'b0),
        .bubble_i (pause),
        .d_i      (exm_d),
        .q_o      (exm_q)
    );

    assign pause_o    = pause;
    assign wb_valid_o = exm_q.valid;
    assign wb_rd_o    = exm_q.rd;
    assign wb_data_o  = exm_q.wb_data;
    assign wb_ale_o   = exm_q.valid && exm_q.ale;

endmodule

`default_nettype wire

/* verif/tb_ex_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module tb_ex_top;
    import ex_pkg::*;

    localparam int CLK_HALF  = 10;
    localparam int DRIVE_DLY = 2;
    localparam int FIELDS    = 10;
    localparam int MAX_OPS   = 64;

    logic     clk;
    logic     rst_n_i;
    logic     in_valid_i;
    alu_op_e  in_op_i;
    bus32_t   in_src1_i;
    bus32_t   in_src2_i;
    bus32_t   in_imm_i;
    reg_idx_t in_rd_i;
    logic     mem_addr_ok_i;
    logic     pause_o;
    logic     mem_req_o;
    logic     mem_we_o;
    bus32_t   mem_addr_o;
    bus32_t   mem_wdata_o;
    strb_t    mem_wstrb_o;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    bus32_t   wb_data_o;
    logic     wb_ale_o;

    // per line: op src1 src2 imm rd wb_data ale mem_addr wstrb wdata
    bus32_t      stim_mem [0:FIELDS*MAX_OPS-1];
    int          n_ops;
    logic        stim_loaded;
    logic        ops_started;
    int          wb_q[$];
    int          mem_q[$];
    int          value_errors;
    int          other_errors;
    int          req_count;
    int          exp_reqs;
    logic [31:0] lcg_state;
    logic        wait_prev;
    bus32_t      wait_addr;
    bus32_t      wait_data;

    ex_top ex_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_src1_i     (in_src1_i),
        .in_src2_i     (in_src2_i),
        .in_imm_i      (in_imm_i),
        .in_rd_i       (in_rd_i),
        .mem_addr_ok_i (mem_addr_ok_i),
        .pause_o       (pause_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_ale_o      (wb_ale_o)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus32_t rec_field(int idx, int k);
        return stim_mem[idx*FIELDS + k];
    endfunction

    function automatic string test_name(int idx, string what);
        return $sformatf("line %0d %s", idx, what);
    endfunction

    task automatic check_word(string name, bus32_t exp, bus32_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_strb(string name, strb_t exp, strb_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // drive one op and hold it until a clock edge sees pause low
    task automatic issue_op(int idx);
        bus32_t  w_op;
        bus32_t  w_rd;
        alu_op_e op;
        logic    accepted;
        w_op = rec_field(idx, 0);
        w_rd = rec_field(idx, 4);
        op   = alu_op_e'(w_op[5:0]);
        in_valid_i  = 1'b1;
        in_op_i     = op;
        in_src1_i   = rec_field(idx, 1);
        in_src2_i   = rec_field(idx, 2);
        in_imm_i    = rec_field(idx, 3);
        in_rd_i     = w_rd[4:0];
        ops_started = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !pause_o;
            @(posedge clk);
        end
        wb_q.push_back(idx);
        if (op inside {OP_LDB, OP_LDH, OP_LDW, OP_STB, OP_STH, OP_STW} &&
            rec_field(idx, 6) == 32'd0) begin
            mem_q.push_back(idx);
            exp_reqs++;
        end
        #(DRIVE_DLY);
    endtask

    // cache side, accepts on about half the cycles
    always @(posedge clk) begin
        #(DRIVE_DLY);
        lcg_state     = lcg_next(lcg_state);
        mem_addr_ok_i = lcg_state[16];
    end

    always @(negedge clk) begin : monitor
        int      idx;
        alu_op_e op;
        bus32_t  w_op;
        bus32_t  w_rd;
        if (!ops_started) begin
            check_flag("idle pause_o", 1'b0, pause_o);
            check_flag("idle mem_req_o", 1'b0, mem_req_o);
            check_flag("idle wb_valid_o", 1'b0, wb_valid_o);
        end
        if (rst_n_i && wb_valid_o) begin
            if (wb_q.size() == 0) begin
                $display("write-back seen with no operation outstanding");
                other_errors++;
            end else begin
                idx  = wb_q.pop_front();
                w_rd = rec_field(idx, 4);
                check_idx(test_name(idx, "wb_rd_o"), w_rd[4:0], wb_rd_o);
                check_word(test_name(idx, "wb_data_o"), rec_field(idx, 5), wb_data_o);
                check_flag(test_name(idx, "wb_ale_o"), rec_field(idx, 6) != 32'd0, wb_ale_o);
            end
        end
        if (rst_n_i) begin
            // a waiting request must stay put
            if (wait_prev && !(mem_req_o && mem_addr_o === wait_addr &&
                               mem_wdata_o === wait_data)) begin
                $display("memory request dropped or changed before addr_ok was seen");
                other_errors++;
            end
            wait_prev = mem_req_o && !mem_addr_ok_i;
            wait_addr = mem_addr_o;
            wait_data = mem_wdata_o;
        end
        if (rst_n_i && mem_req_o && mem_addr_ok_i) begin
            req_count++;
            if (mem_q.size() == 0) begin
                $display("memory request seen that no aligned access asked for");
                other_errors++;
            end else begin
                idx  = mem_q.pop_front();
                w_op = rec_field(idx, 0);
                op   = alu_op_e'(w_op[5:0]);
                check_word(test_name(idx, "mem_addr_o"), rec_field(idx, 7), mem_addr_o);
                check_flag(test_name(idx, "mem_we_o"), op inside {OP_STB, OP_STH, OP_STW},
                           mem_we_o);
                check_strb(test_name(idx, "mem_wstrb_o"), strb_t'(rec_field(idx, 8)),
                           mem_wstrb_o);
                check_word(test_name(idx, "mem_wdata_o"), rec_field(idx, 9), mem_wdata_o);
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = n_ops * (`EX_DIV_CYCLES + 40) + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        in_valid_i    = 1'b0;
        in_op_i       = OP_NOP;
        in_src1_i     = '0;
        in_src2_i     = '0;
        in_imm_i      = '0;
        in_rd_i       = '0;
        mem_addr_ok_i = 1'b0;
        lcg_state     = 32'h9ae0_62b1;
        ops_started   = 1'b0;
        stim_loaded   = 1'b0;
        wait_prev     = 1'b0;
        wait_addr     = '0;
        wait_data     = '0;
        value_errors  = 0;
        other_errors  = 0;
        req_count     = 0;
        exp_reqs      = 0;

        $readmemh("verif/ex_stimulus.txt", stim_mem);
        // ff in the op column ends the list
        n_ops = 0;
        while (n_ops < MAX_OPS && rec_field(n_ops, 0) != 32'h0000_00ff) begin
            n_ops++;
        end
        stim_loaded = 1'b1;
        if (n_ops == 0) begin
            $display("stimulus file holds no operations");
            other_errors++;
        end

        repeat (16) @(posedge clk);
        #(DRIVE_DLY);
        rst_n_i = 1'b1;
        repeat (4) @(posedge clk);
        #(DRIVE_DLY);

        for (int i = 0; i < n_ops; i++) begin
            issue_op(i);
        end
        in_valid_i = 1'b0;
        in_op_i    = OP_NOP;

        while (wb_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (req_count != exp_reqs || mem_q.size() != 0) begin
            $display("saw %0d memory requests where %0d aligned accesses were issued",
                     req_count, exp_reqs);
            other_errors++;
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ex_stimulus.txt */
// columns: op src1 src2 imm rd | expected wb_data ale mem_addr wstrb wdata
// op uses the alu_op_e encoding, a line with op ff ends the list
01 00000005 00000007 00000000 01 0000000c 0 00000000 0 00000000
02 00000003 00000005 00000000 02 fffffffe 0 00000000 0 00000000
03 ffffffff 00000001 00000000 03 00000001 0 00000000 0 00000000
04 ffffffff 00000001 00000000 04 00000000 0 00000000 0 00000000
08 f0f0f0f0 0f0f0f00 00000000 05 0000000f 0 00000000 0 00000000
0b 80000000 00000024 00000000 06 f8000000 0 00000000 0 00000000
09 00000001 0000001f 00000000 07 80000000 0 00000000 0 00000000
0c 00000000 12345000 00000000 08 12345000 0 00000000 0 00000000
0d 00010001 00010001 00000000 09 00020001 0 00000000 0 00000000
0e ffffffff 00000002 00000000 0a ffffffff 0 00000000 0 00000000
0f ffffffff 00000002 00000000 0b 00000001 0 00000000 0 00000000
10 fffffff9 00000002 00000000 0c fffffffd 0 00000000 0 00000000
11 fffffff9 00000002 00000000 0d ffffffff 0 00000000 0 00000000
12 00000064 00000007 00000000 0e 0000000e 0 00000000 0 00000000
13 00000064 00000007 00000000 0f 00000002 0 00000000 0 00000000
10 00000011 00000000 00000000 10 ffffffff 0 00000000 0 00000000
11 fffffff9 00000000 00000000 11 fffffff9 0 00000000 0 00000000
17 00001000 000000ab 00000003 00 00000000 0 00001003 8 ab000000
18 00001000 0000beef 00000002 00 00000000 0 00001002 c beef0000
19 00002000 cafef00d 00000004 00 00000000 0 00002004 f cafef00d
16 00003000 00000008 00000000 12 00000000 0 00003008 f 00000000
15 00003000 00000001 00000000 13 00000000 1 00003001 0 00000000
19 00002000 12345678 00000002 00 00000000 1 00002002 0 00000000
ff 00000000 00000000 00000000 00 00000000 0 00000000 0 00000000

/* compile.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_pipe_reg.sv
hdl/ex_int_alu.sv
hdl/ex_mul_unit.sv
hdl/ex_div_unit.sv
hdl/ex_lsu_agen.sv
hdl/ex_stage.sv
hdl/ex_top.sv
verif/tb_ex_top.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ex_pkg.sv
      - hdl/ex_pipe_reg.sv
      - hdl/ex_int_alu.sv
      - hdl/ex_mul_unit.sv
      - hdl/ex_div_unit.sv
      - hdl/ex_lsu_agen.sv
      - hdl/ex_stage.sv
      - hdl/ex_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/tb_ex_top.sv
